/* Makefile */
# Verilator flow for the divide and square-root unit

VERILATOR ?= verilator
TOP       ?= tb_divsqrt
RTL_TOP   ?= divsqrt_top
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

RTL_SRCS = src/divsqrt_pkg.sv src/divsqrt_pipe.sv src/divsqrt_iter.sv \
           src/divsqrt_ctrl.sv src/divsqrt_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(RTL_SRCS) tb/tb_divsqrt.sv include/divsqrt_tb_vectors.svh $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
+incdir+include
src/divsqrt_pkg.sv
src/divsqrt_pipe.sv
src/divsqrt_iter.sv
src/divsqrt_ctrl.sv
src/divsqrt_top.sv
tb/tb_divsqrt.sv

/* src/divsqrt_ctrl.sv */
`timescale 1ns/1ps

module divsqrt_ctrl import divsqrt_pkg::*; #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                in_valid_i,
  output logic                issue_ready_o,
  input  divsqrt_op_e         op_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                eng_ready_i,
  input  logic                eng_done_i,
  output logic                start_div_o,
  output logic                start_sqrt_o,
  output logic                kill_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [TagWidth-1:0] tag_o,
  output logic                busy_o
);

  // FSM encoding
  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] BUSY = 2'd1;
  localparam logic [1:0] HOLD = 2'd2;

  logic [1:0]          state_q;
  logic [1:0]          state_d;
  // High in the cycle an operation enters the engine
  logic                op_start;
  // Tag of the operation in the engine
  logic [TagWidth-1:0] tag_q;

  // Starts are gated by the FSM ready and suppressed by flush
  assign op_start     = in_valid_i & issue_ready_o & ~flush_i;
  assign start_div_o  = op_start & (op_i == OP_DIV);
  assign start_sqrt_o = op_start & (op_i == OP_SQRT);
  // Flush aborts the engine loop
  assign kill_o       = flush_i;

  // ----------------------------------------------------------------------
  // Issue and completion FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    issue_ready_o = 1'b0;
    out_valid_o   = 1'b0;
    busy_o        = 1'b0;
    case (state_q)
      // Waiting for work
      IDLE: begin
        issue_ready_o = eng_ready_i;
        if (in_valid_i && eng_ready_i) begin
          state_d = BUSY;
        end
      end
      // Engine running
      BUSY: begin
        busy_o = 1'b1;
        if (eng_done_i) begin
          // Present the result in the done cycle
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            state_d       = IDLE;
            // Back to back issue
            issue_ready_o = eng_ready_i;
            if (in_valid_i && eng_ready_i) begin
              state_d = BUSY;
            end
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Result waits for downstream
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d       = IDLE;
          issue_ready_o = eng_ready_i;
          if (in_valid_i && eng_ready_i) begin
            state_d = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush cancels the result and drops the operation
    if (flush_i) begin
      busy_o      = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows the operation through the engine
  always_ff @(posedge clk_i) begin
    if (op_start) begin
      tag_q <= tag_i;
    end
  end

  assign tag_o = tag_q;

endmodule

/* src/divsqrt_iter.sv */
`timescale 1ns/1ps

module divsqrt_iter import divsqrt_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_div_i,
  input  logic              start_sqrt_i,
  input  logic              kill_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  output logic              ready_o,
  output logic              done_o,
  output divsqrt_result_u   result_o,
  output logic              div_zero_o
);

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  logic              start;
  logic              busy_q;
  logic              done_q;
  // Iterations still to run after the current one
  logic [CNT_W-1:0]  cnt_q;
  divsqrt_op_e       op_q;
  logic              dz_q;
  // Partial remainder
  logic [DATA_W-1:0] rem_q;
  // Dividend or radicand, shifted out MSB first
  logic [DATA_W-1:0] rad_q;
  // Quotient or root, shifted in LSB first
  logic [DATA_W-1:0] res_q;
  logic [DATA_W-1:0] dvs_q;

  // Operands of this cycle's iteration
  divsqrt_op_e       op_cur;
  logic [DATA_W-1:0] rem_cur;
  logic [DATA_W-1:0] rad_cur;
  logic [DATA_W-1:0] res_cur;
  logic [DATA_W-1:0] dvs_cur;
  logic [DATA_W-1:0] rem_nxt;
  logic [DATA_W-1:0] rad_nxt;
  logic [DATA_W-1:0] res_nxt;

  // Restoring divide step
  logic [DATA_W:0]     div_shift;
  logic [DATA_W:0]     div_diff;
  logic                div_ge;
  // Digit-by-digit square-root step
  logic [SQ_REM_W+1:0] sq_shift;
  logic [SQ_REM_W+1:0] sq_sub;
  logic [SQ_REM_W+1:0] sq_rem;
  logic                sq_ge;

  // A start never collides with a kill from the control, kill wins anyway
  assign start = (start_div_i | start_sqrt_i) & ~kill_i;

  // First iteration runs in the start cycle straight from the operands
  always_comb begin
    if (start) begin
      op_cur  = start_sqrt_i ? OP_SQRT : OP_DIV;
      rem_cur = '0;
      rad_cur = opa_i;
      res_cur = '0;
      dvs_cur = opb_i;
    end else begin
      op_cur  = op_q;
      rem_cur = rem_q;
      rad_cur = rad_q;
      res_cur = res_q;
      dvs_cur = dvs_q;
    end
  end

  // ----------------------------------------------------------------------
  // Iteration datapath
  // ----------------------------------------------------------------------
  // Bring down one dividend bit and try the divisor
  // A zero divisor always fits, giving all ones and rem equal to the dividend
  always_comb begin
    div_shift = {rem_cur, rad_cur[DATA_W-1]};
    div_diff  = div_shift - {1'b0, dvs_cur};
    div_ge    = div_shift >= {1'b0, dvs_cur};
  end

  // Bring down two radicand bits and try 4*root+1
  always_comb begin
    sq_shift = {rem_cur[SQ_REM_W-1:0], rad_cur[DATA_W-1 -: 2]};
    sq_sub   = (SQ_REM_W+2)'({res_cur[ROOT_W-1:0], 2'b01});
    sq_ge    = sq_shift >= sq_sub;
    sq_rem   = sq_ge ? (sq_shift - sq_sub) : sq_shift;
  end

  always_comb begin
    if (op_cur == OP_DIV) begin
      rem_nxt = div_ge ? div_diff[DATA_W-1:0] : div_shift[DATA_W-1:0];
      rad_nxt = rad_cur << 1;
      res_nxt = {res_cur[DATA_W-2:0], div_ge};
    end else begin
      rem_nxt = DATA_W'(sq_rem[SQ_REM_W-1:0]);
      rad_nxt = rad_cur << 2;
      res_nxt = {res_cur[DATA_W-2:0], sq_ge};
    end
  end

  // ----------------------------------------------------------------------
  // Sequencing
  // ----------------------------------------------------------------------
  // Done rises exactly N cycles after the start cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= start_sqrt_i ? CNT_W'(SQRT_CYCLES - 1) : CNT_W'(DIV_CYCLES - 1);
    end else if (busy_q) begin
      // Last iteration when one is left
      busy_q <= (cnt_q != CNT_W'(1));
      done_q <= (cnt_q == CNT_W'(1));
      cnt_q  <= cnt_q - CNT_W'(1);
    end else begin
      done_q <= 1'b0;
    end
  end

  // Datapath registers hold the result until the next start
  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q  <= op_cur;
      dvs_q <= opb_i;
      dz_q  <= start_div_i & (opb_i == '0);
    end
    if (start || (busy_q && !kill_i)) begin
      rem_q <= rem_nxt;
      rad_q <= rad_nxt;
      res_q <= res_nxt;
    end
  end

  // Result word, decoded by operation
  always_comb begin
    result_o = '0;
    if (op_q == OP_DIV) begin
      result_o.div.quot = res_q;
      result_o.div.rem  = rem_q;
    end else begin
      result_o.sqrt.root = res_q[ROOT_W-1:0];
      result_o.sqrt.rem  = rem_q[SQ_REM_W-1:0];
    end
  end

  assign ready_o    = ~busy_q;
  assign done_o     = done_q;
  assign div_zero_o = dz_q;

endmodule

/* src/divsqrt_pipe.sv */
`timescale 1ns/1ps

module divsqrt_pipe #(
  parameter int unsigned Depth     = 1,
  parameter int unsigned DataWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [DataWidth-1:0] in_data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] out_data_o,
  output logic                 busy_o
);

  // Index i holds the item after i register stages
  logic                 stage_valid [0:Depth];
  logic                 stage_ready [0:Depth];
  logic [DataWidth-1:0] stage_data  [0:Depth];
  // Handshake stays closed until the first clock edge after reset
  logic                 run_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // Stage 0 is the upstream interface itself
  assign stage_valid[0] = in_valid_i & run_q;
  assign stage_data[0]  = in_data_i;
  assign in_ready_o     = stage_ready[0] & run_q;

  for (genvar i = 0; i < Depth; i++) begin : gen_stage
    logic                 valid_q;
    logic [DataWidth-1:0] data_q;
    logic                 load;
    // Advance when the next stage takes our item or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    // Capture payload only for a real item
    assign load           = stage_ready[i] & stage_valid[i];

    // Valid bit, flush drops the item
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  // Downstream ready enters at the last stage
  assign stage_ready[Depth] = out_ready_i;
  assign out_valid_o        = stage_valid[Depth];
  assign out_data_o         = stage_data[Depth];

  // Any valid item, the upstream one included
  always_comb begin
    busy_o = 1'b0;
    for (int i = 0; i <= int'(Depth); i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

/* src/divsqrt_pkg.sv */
package divsqrt_pkg;

  // ----------------------------------------------------------------------
  // Operand and result widths
  // ----------------------------------------------------------------------
  // Dividend, divisor and radicand width
  localparam int unsigned DATA_W   = 16;
  // Integer square root of a DATA_W radicand
  localparam int unsigned ROOT_W   = 8;
  // Square-root remainder never exceeds twice the root
  localparam int unsigned SQ_REM_W = 9;

  // ----------------------------------------------------------------------
  // Engine timing
  // ----------------------------------------------------------------------
  // One quotient bit per iteration
  localparam int unsigned DIV_CYCLES  = 16;
  // One root bit per iteration, two radicand bits consumed each time
  localparam int unsigned SQRT_CYCLES = 8;
  // Iteration counter, wide enough for DIV_CYCLES
  localparam int unsigned CNT_W       = 5;

  // Operation select
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // Divide view, quotient in the upper half
  typedef struct packed {
    logic [DATA_W-1:0] quot;
    logic [DATA_W-1:0] rem;
  } divsqrt_div_res_t;

  // Square-root view, zero padded at the top
  typedef struct packed {
    logic [2*DATA_W-ROOT_W-SQ_REM_W-1:0] pad;
    logic [ROOT_W-1:0]                   root;
    logic [SQ_REM_W-1:0]                 rem;
  } divsqrt_sqrt_res_t;

  // Same 32-bit result word, read according to the operation
  typedef union packed {
    divsqrt_div_res_t  div;
    divsqrt_sqrt_res_t sqrt;
  } divsqrt_result_u;

endpackage

/* src/divsqrt_top.sv */
`timescale 1ns/1ps

module divsqrt_top import divsqrt_pkg::*; #(
  parameter int unsigned NumInRegs  = 1,
  parameter int unsigned NumOutRegs = 1,
  parameter int unsigned TagWidth   = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  divsqrt_op_e         op_i,
  input  logic [DATA_W-1:0]   opa_i,
  input  logic [DATA_W-1:0]   opb_i,
  input  logic [TagWidth-1:0] tag_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output divsqrt_result_u     result_o,
  output logic                div_zero_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                busy_o
);

  // Bundle widths, op plus operands plus tag in, result plus flag plus tag out
  localparam int unsigned InDataW  = 1 + 2 * DATA_W + TagWidth;
  localparam int unsigned ResW     = $bits(divsqrt_result_u);
  localparam int unsigned OutDataW = ResW + 1 + TagWidth;

  // ----------------------------------------------------------------------
  // Input pipeline
  // ----------------------------------------------------------------------
  logic [InDataW-1:0]  in_data;
  logic [InDataW-1:0]  iss_data;
  logic                iss_valid;
  logic                iss_ready;
  logic                in_busy;
  divsqrt_op_e         iss_op;
  logic [DATA_W-1:0]   iss_opa;
  logic [DATA_W-1:0]   iss_opb;
  logic [TagWidth-1:0] iss_tag;

  assign in_data = {op_i, opa_i, opb_i, tag_i};

  divsqrt_pipe #(
    .Depth     (NumInRegs),
    .DataWidth (InDataW)
  ) u_in_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data),
    .out_valid_o (iss_valid),
    .out_ready_i (iss_ready),
    .out_data_o  (iss_data),
    .busy_o      (in_busy)
  );

  // Unpack the issued item
  assign iss_op  = divsqrt_op_e'(iss_data[InDataW-1]);
  assign iss_opa = iss_data[InDataW-2 -: DATA_W];
  assign iss_opb = iss_data[TagWidth +: DATA_W];
  assign iss_tag = iss_data[TagWidth-1:0];

  // ----------------------------------------------------------------------
  // Control and engine
  // ----------------------------------------------------------------------
  logic                start_div;
  logic                start_sqrt;
  logic                kill;
  logic                eng_ready;
  logic                eng_done;
  divsqrt_result_u     eng_result;
  logic                eng_div_zero;
  logic                res_valid;
  logic                res_ready;
  logic [TagWidth-1:0] res_tag;
  logic                ctrl_busy;

  divsqrt_ctrl #(
    .TagWidth (TagWidth)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .in_valid_i    (iss_valid),
    .issue_ready_o (iss_ready),
    .op_i          (iss_op),
    .tag_i         (iss_tag),
    .eng_ready_i   (eng_ready),
    .eng_done_i    (eng_done),
    .start_div_o   (start_div),
    .start_sqrt_o  (start_sqrt),
    .kill_o        (kill),
    .out_valid_o   (res_valid),
    .out_ready_i   (res_ready),
    .tag_o         (res_tag),
    .busy_o        (ctrl_busy)
  );

  divsqrt_iter u_iter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_div_i  (start_div),
    .start_sqrt_i (start_sqrt),
    .kill_i       (kill),
    .opa_i        (iss_opa),
    .opb_i        (iss_opb),
    .ready_o      (eng_ready),
    .done_o       (eng_done),
    .result_o     (eng_result),
    .div_zero_o   (eng_div_zero)
  );

  // ----------------------------------------------------------------------
  // Output pipeline
  // ----------------------------------------------------------------------
  logic [OutDataW-1:0] res_data;
  logic [OutDataW-1:0] out_data;
  logic                out_busy;

  assign res_data = {eng_result, eng_div_zero, res_tag};

  divsqrt_pipe #(
    .Depth     (NumOutRegs),
    .DataWidth (OutDataW)
  ) u_out_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (res_valid),
    .in_ready_o  (res_ready),
    .in_data_i   (res_data),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data),
    .busy_o      (out_busy)
  );

  assign result_o   = out_data[OutDataW-1 -: ResW];
  assign div_zero_o = out_data[TagWidth];
  assign tag_o      = out_data[TagWidth-1:0];

  // Anything in flight anywhere in the unit
  assign busy_o = in_busy | ctrl_busy | out_busy;

endmodule

/* include/divsqrt_tb_vectors.svh */
`ifndef DIVSQRT_TB_VECTORS_SVH
`define DIVSQRT_TB_VECTORS_SVH

// Columns: op, opa, opb, stall cycles of out_ready_i, flush flag
typedef struct packed {
  divsqrt_op_e op;
  logic [15:0] opa;
  logic [15:0] opb;
  logic [7:0]  stall;
  logic        flush;
} vec_t;

localparam int NUM_VECS = 14;

localparam vec_t VECS [NUM_VECS] = '{
  // Plain divides
  '{OP_DIV,  16'd100,   16'd7,     8'd0,  1'b0},
  '{OP_DIV,  16'hffff,  16'd1,     8'd0,  1'b0},
  '{OP_DIV,  16'd0,     16'd5,     8'd0,  1'b0},
  // Divide by zero
  '{OP_DIV,  16'd1234,  16'd0,     8'd0,  1'b0},
  // Square roots, opb is ignored
  '{OP_SQRT, 16'd0,     16'd0,     8'd0,  1'b0},
  '{OP_SQRT, 16'hffff,  16'd3,     8'd0,  1'b0},
  '{OP_SQRT, 16'd1000,  16'hffff,  8'd0,  1'b0},
  // Long back-pressure, later rows keep streaming behind it
  '{OP_DIV,  16'd50000, 16'd3,     8'd70, 1'b0},
  '{OP_SQRT, 16'd4096,  16'd0,     8'd0,  1'b0},
  '{OP_DIV,  16'd777,   16'd0,     8'd0,  1'b0},
  '{OP_SQRT, 16'd99,    16'd0,     8'd0,  1'b0},
  // Dropped while in the engine
  '{OP_DIV,  16'd9999,  16'd100,   8'd0,  1'b1},
  '{OP_SQRT, 16'd12345, 16'd0,     8'd0,  1'b0},
  '{OP_DIV,  16'd300,   16'd17,    8'd0,  1'b0}
};

`endif

/* tb/tb_divsqrt.sv */
`timescale 1ns/1ps

module tb_divsqrt import divsqrt_pkg::*;;

  `include "divsqrt_tb_vectors.svh"

  localparam int NUM_RAND = 20;
  localparam int TIMEOUT  = (NUM_VECS + NUM_RAND) * (int'(DIV_CYCLES) + 10) + 200;

  // One issued item as queued in issue order
  typedef struct packed {
    divsqrt_op_e op;
    logic [15:0] opa;
    logic [15:0] opb;
    logic [3:0]  tag;
  } exp_t;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            flush_i;
  logic            in_valid_i;
  logic            in_ready_o;
  divsqrt_op_e     op_i;
  logic [15:0]     opa_i;
  logic [15:0]     opb_i;
  logic [3:0]      tag_i;
  logic            out_valid_o;
  logic            out_ready_i;
  divsqrt_result_u result_o;
  logic            div_zero_o;
  logic [3:0]      tag_o;
  logic            busy_o;

  exp_t        exp_q [$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          stall_left = 0;
  int          seed = 32'ha7e3;
  logic [3:0]  next_tag = 4'd0;
  logic        saw_in_stall = 1'b0;

  divsqrt_top #(
    .NumInRegs  (1),
    .NumOutRegs (2),
    .TagWidth   (4)
  ) dut_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .opa_i       (opa_i),
    .opb_i       (opb_i),
    .tag_i       (tag_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .div_zero_o  (div_zero_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

  always #4 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Checking and reference model
  // ----------------------------------------------------------------------
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Floor of the square root by counting up
  function automatic int isqrt(input logic [15:0] a);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= int'(a)) begin
      r++;
    end
    return r;
  endfunction

  task automatic check_result(input exp_t e);
    int q;
    int r;
    int root;
    check(32'(tag_o), 32'(e.tag), "tag");
    if (e.op == OP_DIV) begin
      if (e.opb == 16'd0) begin
        q = 32'hffff;
        r = int'(e.opa);
      end else begin
        q = int'(e.opa) / int'(e.opb);
        r = int'(e.opa) % int'(e.opb);
      end
      check(32'(result_o.div.quot), 32'(q), "quotient");
      check(32'(result_o.div.rem), 32'(r), "remainder");
      check(32'(div_zero_o), 32'(e.opb == 16'd0), "div_zero");
    end else begin
      root = isqrt(e.opa);
      check(32'(result_o.sqrt.root), 32'(root), "root");
      check(32'(result_o.sqrt.rem), 32'(int'(e.opa) - root * root), "sqrt remainder");
      check(32'(result_o.sqrt.pad), 32'd0, "sqrt pad");
    end
  endtask

  // Output transfers and timeout sampled on the rising edge
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      if (rst_n_i && !out_ready_i && in_valid_i && !in_ready_o) begin
        saw_in_stall = 1'b1;
      end
      if (rst_n_i && out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected result with tag %0d while nothing was pending", tag_o);
        end else begin
          check_result(exp_q.pop_front());
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Driver
  // ----------------------------------------------------------------------
  // One falling edge with the output stall counter
  task automatic tick();
    @(negedge clk_i);
    out_ready_i = (stall_left == 0);
    if (stall_left > 0) begin
      stall_left--;
    end
  endtask

  // Starts and returns just after a falling edge
  task automatic issue(input divsqrt_op_e op, input logic [15:0] a, input logic [15:0] b,
                       input bit expect_out);
    bit   accepted;
    exp_t item;
    in_valid_i = 1'b1;
    op_i       = op;
    opa_i      = a;
    opb_i      = b;
    tag_i      = next_tag;
    accepted   = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = in_ready_o;
      if (accepted && expect_out) begin
        item = '{op, a, b, next_tag};
        exp_q.push_back(item);
      end
      tick();
    end
    in_valid_i = 1'b0;
    next_tag   = next_tag + 4'd1;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      tick();
    end
  endtask

  // Item is dropped from the engine while nothing else is in flight
  task automatic flush_row(input vec_t v);
    drain();
    issue(v.op, v.opa, v.opb, 1'b0);
    repeat (4) tick();
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    #1;
    check(32'(busy_o), 32'd0, "busy after flush");
  endtask

  initial begin
    logic [31:0] rnd;
    logic [15:0] rb;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    tag_i       = '0;
    out_ready_i = 1'b1;
    repeat (10) @(negedge clk_i);
    // Quiet outputs while in reset
    check(32'(in_ready_o), 32'd0, "in_ready in reset");
    check(32'(out_valid_o), 32'd0, "out_valid in reset");
    check(32'(busy_o), 32'd0, "busy in reset");
    rst_n_i = 1'b1;
    @(posedge clk_i);
    tick();
    check(32'(in_ready_o), 32'd1, "in_ready after reset");
    check(32'(out_valid_o), 32'd0, "out_valid after reset");
    check(32'(busy_o), 32'd0, "busy after reset");

    // Directed table
    for (int i = 0; i < NUM_VECS; i++) begin
      if (VECS[i].flush) begin
        flush_row(VECS[i]);
      end else begin
        if (VECS[i].stall != 8'd0) begin
          stall_left  = int'(VECS[i].stall);
          out_ready_i = 1'b0;
        end
        issue(VECS[i].op, VECS[i].opa, VECS[i].opb, 1'b1);
      end
    end

    // Random rows with a zero divisor now and then
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd = $random(seed);
      rb  = (rnd[30:28] == 3'd0) ? 16'd0 : rnd[15:0] >> rnd[27:24];
      issue(divsqrt_op_e'(rnd[31]), rnd[23:8], rb, 1'b1);
    end

    drain();
    repeat (20) tick();
    check(32'(saw_in_stall), 32'd1, "in_ready dropped under back-pressure");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
